// File: hdl/endpoint_pkg.sv
package endpoint_pkg;

    // Cache geometry.
    localparam int cache_words = 128;
    localparam int cache_aw = 7;

    localparam int bus_aw = 14;
    localparam int node_w = 4;
    localparam int len_w = 4;

    // Header word fields. Bits above the source id are user data.
    localparam int hdr_len_lsb = 0;
    localparam int hdr_src_lsb = 4;

    // Bus address map in byte addresses.
    localparam logic [bus_aw-1:0] start_reg_base = 14'h0000;
    localparam logic [bus_aw-1:0] tx_send_addr = 14'h1004;
    localparam logic [bus_aw-1:0] tx_cache_base = 14'h2000;
    localparam logic [bus_aw-1:0] rx_cache_base = 14'h3000;
    localparam logic [bus_aw-1:0] req_fifo_addr = 14'h3400;

    // Requestor FIFO record layout.
    localparam int rec_w = node_w + len_w + cache_aw;
    localparam int rec_addr_lsb = 0;
    localparam int rec_len_lsb = cache_aw;
    localparam int rec_src_lsb = cache_aw + len_w;

    typedef enum logic {BUS, FSM} owner_e;

    typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_REQ, TX_WAIT_ACK_LOW} tx_state_e;

    typedef enum logic [1:0] {RX_IDLE, RX_ACK, RX_WAIT_REQ_LOW, RX_PUSH} rx_state_e;

endpackage

// File: hdl/word_cache.sv
`timescale 1ns/100ps

module word_cache (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             wen,
    input  logic                             ren,
    input  logic [endpoint_pkg::cache_aw-1:0] addr,
    input  logic [31:0]                      wdata,
    output logic [31:0]                      rdata
);
    import endpoint_pkg::*;

    logic [31:0] mem [cache_words];

    // Register file cleared on reset.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < cache_words; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[addr] <= wdata;
        end
    end

    // Read is combinational.
    always_comb begin
        if (ren) begin
            rdata = mem[addr];
        end else begin
            rdata = '0;
        end
    end

endmodule

// File: hdl/tx_fsm.sv
`timescale 1ns/100ps

module tx_fsm #(
    parameter int NUM_MSGS = 4
) (
    input  logic                                            clk,
    input  logic                                            n_rst,
    input  logic [endpoint_pkg::node_w-1:0]                 node_id,
    input  logic [NUM_MSGS-1:0]                             trigger_send,
    input  logic [NUM_MSGS-1:0][endpoint_pkg::cache_aw-1:0] start_addr,
    input  logic [31:0]                                     cache_rdata,
    input  logic                                            cache_stall,
    input  logic                                            tx_ack,
    output logic                                            cache_ren,
    output logic [endpoint_pkg::cache_aw-1:0]               cache_addr,
    output logic                                            tx_req,
    output logic [31:0]                                     tx_data
);
    import endpoint_pkg::*;

    localparam int idx_w = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1;

    tx_state_e state;
    logic [NUM_MSGS-1:0] pending;
    logic [NUM_MSGS-1:0] done_mask;
    logic [idx_w-1:0] next_idx;
    logic [idx_w-1:0] cur_idx;
    logic [cache_aw-1:0] rd_addr;
    logic [len_w-1:0] words_left;
    logic first_word;
    logic [31:0] hdr_word;
    logic last_done;

    // Lowest pending message wins.
    always_comb begin
        next_idx = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_idx = idx_w'(i);
            end
        end
    end

    always_comb begin
        hdr_word = cache_rdata;
        hdr_word[hdr_src_lsb +: node_w] = node_id;
    end

    assign cache_ren = (state == TX_LOAD);
    assign cache_addr = rd_addr;
    assign last_done = (state == TX_WAIT_ACK_LOW) && !tx_ack && (words_left == '0);

    always_comb begin
        done_mask = '0;
        done_mask[cur_idx] = last_done;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~done_mask) | trigger_send;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= TX_IDLE;
            tx_req <= 1'b0;
            cur_idx <= '0;
            rd_addr <= '0;
            words_left <= '0;
            first_word <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (|pending) begin
                        cur_idx <= next_idx;
                        rd_addr <= start_addr[next_idx];
                        first_word <= 1'b1;
                        state <= TX_LOAD;
                    end
                end
                TX_LOAD: begin
                    if (!cache_stall) begin
                        first_word <= 1'b0;
                        if (first_word) begin
                            words_left <= cache_rdata[hdr_len_lsb +: len_w];
                        end else begin
                            words_left <= words_left - 1'b1;
                        end
                        tx_req <= 1'b1;
                        state <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state <= TX_WAIT_ACK_LOW;
                    end
                end
                TX_WAIT_ACK_LOW: begin
                    if (last_done) begin
                        state <= TX_IDLE;
                    end else if (!tx_ack) begin
                        rd_addr <= rd_addr + 1'b1;
                        state <= TX_LOAD;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data only changes while req is low.
    always_ff @(posedge clk) begin
        if (state == TX_LOAD && !cache_stall) begin
            tx_data <= first_word ? hdr_word : cache_rdata;
        end
    end

endmodule

// File: hdl/rx_fsm.sv
`timescale 1ns/100ps

module rx_fsm (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              rx_req,
    input  logic [31:0]                       rx_data,
    input  logic                              cache_stall,
    input  logic                              fifo_full,
    output logic                              rx_ack,
    output logic                              cache_wen,
    output logic [endpoint_pkg::cache_aw-1:0] cache_addr,
    output logic [31:0]                       cache_wdata,
    output logic                              push,
    output logic [endpoint_pkg::rec_w-1:0]    record
);
    import endpoint_pkg::*;

    rx_state_e state;
    logic [cache_aw-1:0] wr_ptr;
    logic expect_hdr;
    logic [len_w-1:0] words_left;
    logic [node_w-1:0] rec_src;
    logic [len_w-1:0] rec_len;
    logic [cache_aw-1:0] rec_addr;

    assign cache_wen = (state == RX_ACK);
    assign cache_addr = wr_ptr;
    assign cache_wdata = rx_data;
    assign push = (state == RX_PUSH);

    always_comb begin
        record = '0;
        record[rec_src_lsb +: node_w] = rec_src;
        record[rec_len_lsb +: len_w] = rec_len;
        record[rec_addr_lsb +: cache_aw] = rec_addr;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= RX_IDLE;
            rx_ack <= 1'b0;
            wr_ptr <= '0;
            expect_hdr <= 1'b1;
            words_left <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    // No new header while the FIFO is full.
                    if (rx_req && !(expect_hdr && fifo_full)) begin
                        state <= RX_ACK;
                    end
                end
                RX_ACK: begin
                    if (!cache_stall) begin
                        rx_ack <= 1'b1;
                        wr_ptr <= wr_ptr + 1'b1;
                        expect_hdr <= 1'b0;
                        if (expect_hdr) begin
                            words_left <= rx_data[hdr_len_lsb +: len_w];
                        end else begin
                            words_left <= words_left - 1'b1;
                        end
                        state <= RX_WAIT_REQ_LOW;
                    end
                end
                RX_WAIT_REQ_LOW: begin
                    if (!rx_req) begin
                        rx_ack <= 1'b0;
                        if (words_left == '0) begin
                            expect_hdr <= 1'b1;
                            state <= RX_PUSH;
                        end else begin
                            state <= RX_IDLE;
                        end
                    end
                end
                RX_PUSH: state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Record fields captured from the header.
    always_ff @(posedge clk) begin
        if (state == RX_ACK && !cache_stall && expect_hdr) begin
            rec_src <= rx_data[hdr_src_lsb +: node_w];
            rec_len <= rx_data[hdr_len_lsb +: len_w];
            rec_addr <= wr_ptr;
        end
    end

endmodule

// File: hdl/req_fifo.sv
`timescale 1ns/100ps

module req_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           push,
    input  logic [endpoint_pkg::rec_w-1:0] record,
    input  logic                           pop,
    output logic [endpoint_pkg::rec_w-1:0] head,
    output logic                           full,
    output logic                           packet_recv
);
    import endpoint_pkg::*;

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [rec_w-1:0] mem [DEPTH];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic empty;
    logic do_push;
    logic do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == cnt_w'(DEPTH));
    assign do_pop = pop && !empty;
    assign do_push = push && (!full || do_pop);
    assign head = empty ? '0 : mem[rd_ptr];
    assign packet_recv = !empty;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= record;
        end
    end

endmodule

// File: hdl/endpoint.sv
`timescale 1ns/100ps

module endpoint #(
    parameter int NUM_MSGS = 4,
    parameter int DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic [endpoint_pkg::node_w-1:0] node_id,
    input  logic                            bus_wen,
    input  logic                            bus_ren,
    input  logic [endpoint_pkg::bus_aw-1:0] bus_addr,
    input  logic [31:0]                     bus_wdata,
    output logic [31:0]                     bus_rdata,
    output logic                            bus_error,
    output logic                            bus_stall,
    output logic                            tx_req,
    input  logic                            tx_ack,
    output logic [31:0]                     tx_data,
    input  logic                            rx_req,
    output logic                            rx_ack,
    input  logic [31:0]                     rx_data,
    output logic                            packet_recv
);
    import endpoint_pkg::*;

    localparam int idx_w = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1;

    logic [NUM_MSGS-1:0][cache_aw-1:0] start_regs;
    logic [NUM_MSGS-1:0] trigger_send;
    logic start_wen;
    logic [idx_w-1:0] start_idx;
    owner_e tx_owner;
    owner_e rx_owner;
    logic tx_fsm_ren;
    logic [cache_aw-1:0] tx_fsm_addr;
    logic rx_fsm_wen;
    logic [cache_aw-1:0] rx_fsm_addr;
    logic [31:0] rx_fsm_wdata;
    logic tx_c_wen, tx_c_ren;
    logic [cache_aw-1:0] tx_c_addr;
    logic [31:0] tx_c_rdata;
    logic rx_c_wen, rx_c_ren;
    logic [cache_aw-1:0] rx_c_addr;
    logic [31:0] rx_c_rdata;
    logic fifo_push, fifo_pop, fifo_full;
    logic [rec_w-1:0] fifo_record, fifo_head;
    logic [bus_aw-1:0] reg_off, tx_off, rx_off;
    logic in_regs, in_tx, in_rx;
    logic [cache_aw-1:0] bus_word;

    assign reg_off = bus_addr - start_reg_base;
    assign tx_off = bus_addr - tx_cache_base;
    assign rx_off = bus_addr - rx_cache_base;
    assign in_regs = reg_off < bus_aw'(NUM_MSGS * 4);
    assign in_tx = (bus_addr >= tx_cache_base) && (tx_off < bus_aw'(cache_words * 4));
    assign in_rx = (bus_addr >= rx_cache_base) && (rx_off < bus_aw'(cache_words * 4));
    assign start_idx = reg_off[2 +: idx_w];
    assign bus_word = bus_addr[cache_aw+1:2];

    always_comb begin
        bus_rdata = '0;
        bus_error = 1'b0;
        bus_stall = 1'b0;
        start_wen = 1'b0;
        trigger_send = '0;
        fifo_pop = 1'b0;
        tx_c_wen = 1'b0;
        tx_c_ren = 1'b0;
        tx_c_addr = bus_word;
        rx_c_wen = 1'b0;
        rx_c_ren = 1'b0;
        rx_c_addr = bus_word;
        if (in_regs) begin
            start_wen = bus_wen;
            bus_rdata = 32'({start_regs[start_idx], 2'b00});
        end else if (bus_addr == tx_send_addr) begin
            if (bus_wen && bus_wdata < 32'(NUM_MSGS)) begin
                trigger_send[bus_wdata[idx_w-1:0]] = 1'b1;
            end else begin
                bus_error = bus_wen || bus_ren;
            end
        end else if (in_tx) begin
            if (tx_owner == FSM) begin
                bus_stall = bus_wen || bus_ren;
            end else begin
                tx_c_wen = bus_wen;
                tx_c_ren = bus_ren;
                bus_rdata = tx_c_rdata;
            end
        end else if (in_rx) begin
            // Read only from the bus side.
            if (bus_wen) begin
                bus_error = 1'b1;
            end else if (rx_owner == FSM) begin
                bus_stall = bus_ren;
            end else begin
                rx_c_ren = bus_ren;
                bus_rdata = rx_c_rdata;
            end
        end else if (bus_addr == req_fifo_addr && !bus_wen) begin
            fifo_pop = bus_ren;
            bus_rdata = 32'(fifo_head);
        end else begin
            bus_error = bus_wen || bus_ren;
        end

        if (tx_owner == FSM) begin
            tx_c_ren = tx_fsm_ren;
            tx_c_addr = tx_fsm_addr;
        end
        if (rx_owner == FSM) begin
            rx_c_wen = rx_fsm_wen;
            rx_c_addr = rx_fsm_addr;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            start_regs <= '0;
            tx_owner <= BUS;
            rx_owner <= BUS;
        end else begin
            if (start_wen) begin
                start_regs[start_idx] <= bus_wdata[cache_aw+1:2];
            end
            tx_owner <= tx_fsm_ren ? FSM : BUS;
            rx_owner <= rx_fsm_wen ? FSM : BUS;
        end
    end

    word_cache tx_cache (
        .clk(clk), .n_rst(n_rst), .wen(tx_c_wen), .ren(tx_c_ren),
        .addr(tx_c_addr), .wdata(bus_wdata), .rdata(tx_c_rdata)
    );

    word_cache rx_cache (
        .clk(clk), .n_rst(n_rst), .wen(rx_c_wen), .ren(rx_c_ren),
        .addr(rx_c_addr), .wdata(rx_fsm_wdata), .rdata(rx_c_rdata)
    );

    tx_fsm #(.NUM_MSGS(NUM_MSGS)) i_tx_fsm (
        .clk(clk), .n_rst(n_rst), .node_id(node_id), .trigger_send(trigger_send),
        .start_addr(start_regs), .cache_rdata(tx_c_rdata),
        .cache_stall(tx_owner != FSM), .tx_ack(tx_ack), .cache_ren(tx_fsm_ren),
        .cache_addr(tx_fsm_addr), .tx_req(tx_req), .tx_data(tx_data)
    );

    rx_fsm i_rx_fsm (
        .clk(clk), .n_rst(n_rst), .rx_req(rx_req), .rx_data(rx_data),
        .cache_stall(rx_owner != FSM), .fifo_full(fifo_full), .rx_ack(rx_ack),
        .cache_wen(rx_fsm_wen), .cache_addr(rx_fsm_addr), .cache_wdata(rx_fsm_wdata),
        .push(fifo_push), .record(fifo_record)
    );

    req_fifo #(.DEPTH(DEPTH)) i_req_fifo (
        .clk(clk), .n_rst(n_rst), .push(fifo_push), .record(fifo_record),
        .pop(fifo_pop), .head(fifo_head), .full(fifo_full), .packet_recv(packet_recv)
    );

endmodule

// File: testbench/endpoint_properties.sv
`timescale 1ns/100ps

module endpoint_properties (
    input logic        clk,
    input logic        n_rst,
    input logic        tx_req,
    input logic        tx_ack,
    input logic [31:0] tx_data,
    input logic        rx_req,
    input logic        rx_ack,
    input logic        bus_error,
    input logic        bus_stall
);

    // An offered word stays offered until it is taken.
    req_held: assert property (@(posedge clk) disable iff (!n_rst)
        tx_req && !tx_ack |=> tx_req)
        else $error("tx_req dropped before tx_ack rose");

    data_stable: assert property (@(posedge clk) disable iff (!n_rst)
        $past(tx_req) && tx_req |-> $stable(tx_data))
        else $error("tx_data changed while tx_req was high");

    ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(rx_ack) |-> rx_req)
        else $error("rx_ack rose without rx_req");

    error_or_stall: assert property (@(posedge clk) disable iff (!n_rst)
        !(bus_error && bus_stall))
        else $error("bus_error and bus_stall high together");

endmodule

bind endpoint endpoint_properties i_endpoint_properties (
    .clk(clk), .n_rst(n_rst), .tx_req(tx_req), .tx_ack(tx_ack), .tx_data(tx_data),
    .rx_req(rx_req), .rx_ack(rx_ack), .bus_error(bus_error), .bus_stall(bus_stall)
);

// File: testbench/endpoint_tb.sv
`timescale 1ns/100ps

module endpoint_tb;
    import endpoint_pkg::*;

    localparam int num_msgs = 4;
    localparam int max_entries = 128;
    localparam logic [node_w-1:0] my_node = 4'd5;

    typedef enum logic [1:0] {E_WR, E_RD, E_ERR, E_POLL} entry_e;

    logic clk;
    logic n_rst;
    logic bus_wen;
    logic bus_ren;
    logic [bus_aw-1:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic bus_error;
    logic bus_stall;
    logic link_req;
    logic link_ack;
    logic [31:0] link_data;
    logic packet_recv;

    // One bus access per table entry.
    entry_e e_kind [max_entries];
    int e_test [max_entries];
    logic e_wr [max_entries];
    logic [bus_aw-1:0] e_addr [max_entries];
    logic [31:0] e_data [max_entries];
    int e_cnt [max_entries];
    int n_entries;
    logic table_ready;

    logic [31:0] tx_model [cache_words];
    logic [cache_aw-1:0] rx_ptr;
    logic [31:0] lcg_state;
    int errors;
    int test_errors [7];
    string test_names [7];

    // The outgoing link loops back to the incoming one.
    endpoint #(.NUM_MSGS(num_msgs), .DEPTH(2)) i_endpoint (
        .clk(clk), .n_rst(n_rst), .node_id(my_node),
        .bus_wen(bus_wen), .bus_ren(bus_ren), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata), .bus_error(bus_error), .bus_stall(bus_stall),
        .tx_req(link_req), .tx_ack(link_ack), .tx_data(link_data),
        .rx_req(link_req), .rx_ack(link_ack), .rx_data(link_data),
        .packet_recv(packet_recv)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [bus_aw-1:0] reg_addr(input int m);
        return start_reg_base + bus_aw'(m * 4);
    endfunction

    function automatic logic [bus_aw-1:0] tx_addr(input int w);
        return tx_cache_base + bus_aw'((w % cache_words) * 4);
    endfunction

    function automatic logic [bus_aw-1:0] rx_addr(input int w);
        return rx_cache_base + bus_aw'((w % cache_words) * 4);
    endfunction

    task automatic add_entry(input entry_e kind, input int t, input logic wr,
                             input logic [bus_aw-1:0] addr, input logic [31:0] data,
                             input int cnt);
        e_kind[n_entries] = kind;
        e_test[n_entries] = t;
        e_wr[n_entries] = wr;
        e_addr[n_entries] = addr;
        e_data[n_entries] = data;
        e_cnt[n_entries] = cnt;
        n_entries++;
    endtask

    // Header with a foreign source id, then nonzero payload words.
    task automatic load_packet(input int t, input int msg, input int w, input int len);
        logic [31:0] word;
        word = lcg_next();
        word[hdr_src_lsb +: node_w] = 4'ha;
        word[hdr_len_lsb +: len_w] = len_w'(len);
        add_entry(E_WR, t, 1'b1, reg_addr(msg), 32'(w * 4), 1);
        for (int i = 0; i <= len; i++) begin
            if (i > 0) begin
                word = lcg_next() | 32'h1;
            end
            tx_model[(w + i) % cache_words] = word;
            add_entry(E_WR, t, 1'b1, tx_addr(w + i), word, 1);
        end
    endtask

    task automatic expect_packet(input int t, input int w);
        int len;
        logic [31:0] word;
        logic [31:0] rec;
        len = int'(tx_model[w][hdr_len_lsb +: len_w]);
        rec = '0;
        rec[rec_src_lsb +: node_w] = my_node;
        rec[rec_len_lsb +: len_w] = len_w'(len);
        rec[rec_addr_lsb +: cache_aw] = rx_ptr;
        add_entry(E_POLL, t, 1'b0, req_fifo_addr, rec, 200);
        for (int i = 0; i <= len; i++) begin
            word = tx_model[(w + i) % cache_words];
            if (i == 0) begin
                word[hdr_src_lsb +: node_w] = my_node;
            end
            add_entry(E_RD, t, 1'b0, rx_addr(int'(rx_ptr)), word, 1);
            rx_ptr = rx_ptr + 1'b1;
        end
    endtask

    // Driven 1 ns after the edge, sampled 3 ns after it.
    task automatic bus_access(input logic wr, input logic [bus_aw-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output logic recv);
        bus_wen = wr;
        bus_ren = !wr;
        bus_addr = addr;
        bus_wdata = wdata;
        #2;
        while (bus_stall) begin
            #4;
        end
        rdata = bus_rdata;
        err = bus_error;
        recv = packet_recv;
        @(posedge clk);
        #1;
        bus_wen = 1'b0;
        bus_ren = 1'b0;
    endtask

    task automatic count_error(input int i);
        errors++;
        test_errors[e_test[i]]++;
    endtask

    task automatic run_entry(input int i);
        logic [31:0] rdata;
        logic err;
        logic recv;
        int tries;
        rdata = '0;
        tries = 0;
        case (e_kind[i])
            E_WR: begin
                bus_access(1'b1, e_addr[i], e_data[i], rdata, err, recv);
                if (err) begin
                    $display("FAIL %0t: write to %h raised bus_error", $time, e_addr[i]);
                    count_error(i);
                end
            end
            E_RD: begin
                for (int n = 0; n < e_cnt[i]; n++) begin
                    bus_access(1'b0, e_addr[i], '0, rdata, err, recv);
                    if (err || rdata !== e_data[i]) begin
                        $display("FAIL %0t: read %h gave %h, expected %h", $time,
                                 e_addr[i], rdata, e_data[i]);
                        count_error(i);
                    end
                    if (e_addr[i] == req_fifo_addr && recv !== (e_data[i] != 0)) begin
                        $display("FAIL %0t: packet_recv is %b", $time, recv);
                        count_error(i);
                    end
                end
            end
            E_ERR: begin
                bus_access(e_wr[i], e_addr[i], e_data[i], rdata, err, recv);
                if (!err) begin
                    $display("FAIL %0t: access to %h gave no bus_error", $time, e_addr[i]);
                    count_error(i);
                end
            end
            default: begin
                while (rdata == 0 && tries < e_cnt[i]) begin
                    bus_access(1'b0, e_addr[i], '0, rdata, err, recv);
                    tries++;
                end
                if (rdata == 0) begin
                    $display("Polling %h found nothing after %0d reads", e_addr[i], tries);
                    count_error(i);
                end else if (rdata !== e_data[i]) begin
                    $display("FAIL %0t: poll of %h gave %h, expected %h", $time,
                             e_addr[i], rdata, e_data[i]);
                    count_error(i);
                end else if (e_addr[i] == req_fifo_addr && recv !== 1'b1) begin
                    $display("FAIL %0t: packet_recv low with a record queued", $time);
                    count_error(i);
                end
            end
        endcase
    endtask

    initial begin
        wait (table_ready);
        repeat (n_entries * 200) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", n_entries * 200);
        $display("Errors found");
        $finish;
    end

    initial begin
        int base;
        logic [31:0] v;
        n_rst = 1'b0;
        bus_wen = 1'b0;
        bus_ren = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        table_ready = 1'b0;
        n_entries = 0;
        errors = 0;
        rx_ptr = '0;
        lcg_state = 32'd29932;
        test_names[1] = "start registers";
        test_names[2] = "tx cache and bus errors";
        test_names[3] = "loopback";
        test_names[4] = "message order";
        test_names[5] = "back-pressure";
        test_names[6] = "empty fifo";

        for (int m = 0; m < num_msgs; m++) begin
            v = lcg_next() & 32'h1ff;
            add_entry(E_WR, 1, 1'b1, reg_addr(m), v, 1);
            add_entry(E_RD, 1, 1'b0, reg_addr(m), v & ~32'h3, 1);
        end

        for (int w = 100; w < 104; w++) begin
            tx_model[w] = lcg_next();
            add_entry(E_WR, 2, 1'b1, tx_addr(w), tx_model[w], 1);
        end
        for (int w = 100; w < 104; w++) begin
            add_entry(E_RD, 2, 1'b0, tx_addr(w), tx_model[w], 1);
        end
        add_entry(E_ERR, 2, 1'b1, rx_addr(0), 32'h1234, 1);
        add_entry(E_ERR, 2, 1'b1, tx_send_addr, 32'(num_msgs), 1);
        add_entry(E_ERR, 2, 1'b0, 14'h1000, '0, 1);

        load_packet(3, 0, 0, 3);
        add_entry(E_WR, 3, 1'b1, tx_send_addr, 32'd0, 1);
        expect_packet(3, 0);

        // Message 3 keeps the sender busy while 1 and 0 are triggered.
        load_packet(4, 3, 10, 2);
        load_packet(4, 1, 20, 4);
        load_packet(4, 0, 30, 1);
        add_entry(E_WR, 4, 1'b1, tx_send_addr, 32'd3, 1);
        add_entry(E_WR, 4, 1'b1, tx_send_addr, 32'd1, 1);
        add_entry(E_WR, 4, 1'b1, tx_send_addr, 32'd0, 1);
        expect_packet(4, 10);
        expect_packet(4, 30);
        expect_packet(4, 20);

        load_packet(5, 0, 40, 2);
        load_packet(5, 1, 50, 3);
        load_packet(5, 2, 60, 1);
        for (int m = 0; m < 3; m++) begin
            add_entry(E_WR, 5, 1'b1, tx_send_addr, 32'(m), 1);
        end
        base = int'(rx_ptr);
        // Last payload word of the second packet.
        add_entry(E_POLL, 5, 1'b0, rx_addr(base + 6), tx_model[53], 200);
        // Both slots full, so the third header stays out of the cache.
        add_entry(E_RD, 5, 1'b0, rx_addr(base + 7), 32'd0, 20);
        expect_packet(5, 40);
        expect_packet(5, 50);
        expect_packet(5, 60);

        add_entry(E_RD, 6, 1'b0, req_fifo_addr, 32'd0, 1);
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        #1;
        n_rst = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
            if (i == n_entries - 1 || e_test[i + 1] != e_test[i]) begin
                if (test_errors[e_test[i]] == 0) begin
                    $display("Test %0d (%s) passed", e_test[i], test_names[e_test[i]]);
                end else begin
                    $display("Test %0d (%s) failed with %0d errors", e_test[i],
                             test_names[e_test[i]], test_errors[e_test[i]]);
                end
            end
        end
        $display("Ran %0d entries in 6 tests, %0d errors", n_entries, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/endpoint_pkg.sv
hdl/word_cache.sv
hdl/tx_fsm.sv
hdl/rx_fsm.sv
hdl/req_fifo.sv
hdl/endpoint.sv
testbench/endpoint_properties.sv
testbench/endpoint_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= endpoint_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
